// ==== hw/exu_op_pkg.sv ====
package exu_op_pkg;

    // ------------------------------
    // arithmetic unit
    // ------------------------------

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        // operand b straight through, used by lui
        alu_pass_b = 4'd10
    } alu_op_e;

    typedef enum logic {
        src_a_rs1 = 1'b0,
        src_a_pc  = 1'b1
    } src_a_e;

    typedef enum logic {
        src_b_rs2 = 1'b0,
        src_b_imm = 1'b1
    } src_b_e;

    // ------------------------------
    // control flow
    // ------------------------------

    typedef enum logic [3:0] {
        br_none = 4'd0,
        br_jal  = 4'd1,
        br_jalr = 4'd2,
        br_beq  = 4'd3,
        br_bne  = 4'd4,
        br_blt  = 4'd5,
        br_bge  = 4'd6,
        br_bltu = 4'd7,
        br_bgeu = 4'd8
    } br_op_e;

    // ------------------------------
    // memory access
    // ------------------------------

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_size_e;

endpackage

// ==== hw/exu_bus_pkg.sv ====
package exu_bus_pkg;

    localparam int XLEN_DEFAULT = 32;
    localparam int REG_IDX_W = 5;

    // ------------------------------
    // decode to execute
    // ------------------------------

    typedef struct packed {
        exu_op_pkg::alu_op_e        alu_op;
        exu_op_pkg::src_a_e         src_a;
        exu_op_pkg::src_b_e         src_b;
        exu_op_pkg::br_op_e         br_op;
        exu_op_pkg::mem_op_e        mem_op;
        exu_op_pkg::mem_size_e      mem_size;
        logic                       mem_unsigned;
        logic [REG_IDX_W-1:0]       rd_idx;
        logic [REG_IDX_W-1:0]       rs1_idx;
        logic [REG_IDX_W-1:0]       rs2_idx;
        logic                       rd_en;
        logic [XLEN_DEFAULT-1:0]    pc;
        logic [XLEN_DEFAULT-1:0]    imm;
        logic [XLEN_DEFAULT-1:0]    rs1;
        logic [XLEN_DEFAULT-1:0]    rs2;
    } exu_in_t;

    // ------------------------------
    // execute to memory/writeback
    // ------------------------------

    // result is the address for loads and stores, pc+4 for jumps
    typedef struct packed {
        logic [REG_IDX_W-1:0]       rd_idx;
        logic                       rd_en;
        logic [XLEN_DEFAULT-1:0]    result;
        exu_op_pkg::mem_op_e        mem_op;
        exu_op_pkg::mem_size_e      mem_size;
        logic                       mem_unsigned;
        logic [XLEN_DEFAULT-1:0]    store_data;
    } exu_out_t;

    // unit outputs inside the stage
    typedef struct packed {
        logic [XLEN_DEFAULT-1:0]    result;
    } alu_res_t;

    typedef struct packed {
        logic                       taken;
        logic [XLEN_DEFAULT-1:0]    target;
    } br_res_t;

endpackage

// ==== hw/exu_alu.sv ====
`timescale 1ns/1ps

module exu_alu #(
    parameter int XLEN = 32
) (
    input  exu_bus_pkg::exu_in_t  instr,
    output exu_bus_pkg::alu_res_t alu_res
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic [XLEN-1:0]    result;
    logic [SHAMT_W-1:0] shamt;

    // ------------------------------
    // operand select
    // ------------------------------

    // jumps come in as pc + 4 through these selects
    assign op_a = (instr.src_a == exu_op_pkg::src_a_pc) ? instr.pc : instr.rs1;
    assign op_b = (instr.src_b == exu_op_pkg::src_b_imm) ? instr.imm : instr.rs2;
    assign shamt = op_b[SHAMT_W-1:0];

    // ------------------------------
    // operation
    // ------------------------------

    always_comb begin
        case (instr.alu_op)
            exu_op_pkg::alu_add:    result = op_a + op_b;
            exu_op_pkg::alu_sub:    result = op_a - op_b;
            exu_op_pkg::alu_sll:    result = op_a << shamt;
            exu_op_pkg::alu_slt:    result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            exu_op_pkg::alu_sltu:   result = {{(XLEN-1){1'b0}}, op_a < op_b};
            exu_op_pkg::alu_xor:    result = op_a ^ op_b;
            exu_op_pkg::alu_srl:    result = op_a >> shamt;
            // arithmetic shift keeps the sign of a
            exu_op_pkg::alu_sra:    result = $signed(op_a) >>> shamt;
            exu_op_pkg::alu_or:     result = op_a | op_b;
            exu_op_pkg::alu_and:    result = op_a & op_b;
            exu_op_pkg::alu_pass_b: result = op_b;
            default:                result = '0;
        endcase
    end

    assign alu_res.result = result;

    // an op outside the table must never reach a register or an address
    always_comb begin
        if (instr.rd_en || instr.mem_op != exu_op_pkg::mem_none) begin
            assert (instr.alu_op inside {[exu_op_pkg::alu_add:exu_op_pkg::alu_pass_b]})
                else $error("exu_alu: illegal alu_op %0d", instr.alu_op);
        end
    end

endmodule

// ==== hw/exu_branch.sv ====
`timescale 1ns/1ps

module exu_branch #(
    parameter int XLEN = 32
) (
    input  exu_bus_pkg::exu_in_t instr,
    output exu_bus_pkg::br_res_t br_res
);

    logic [XLEN-1:0] cmp_a;
    logic [XLEN-1:0] cmp_b;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] sum;
    logic            is_jalr;
    logic            eq;
    logic            lt;
    logic            ltu;

    // ------------------------------
    // compare
    // ------------------------------

    assign cmp_a = instr.rs1;
    assign cmp_b = instr.rs2;
    assign eq = cmp_a == cmp_b;
    assign lt = $signed(cmp_a) < $signed(cmp_b);
    assign ltu = cmp_a < cmp_b;

    always_comb begin
        case (instr.br_op)
            exu_op_pkg::br_jal:  br_res.taken = 1'b1;
            exu_op_pkg::br_jalr: br_res.taken = 1'b1;
            exu_op_pkg::br_beq:  br_res.taken = eq;
            exu_op_pkg::br_bne:  br_res.taken = !eq;
            exu_op_pkg::br_blt:  br_res.taken = lt;
            exu_op_pkg::br_bge:  br_res.taken = !lt;
            exu_op_pkg::br_bltu: br_res.taken = ltu;
            exu_op_pkg::br_bgeu: br_res.taken = !ltu;
            default:             br_res.taken = 1'b0;
        endcase
    end

    // ------------------------------
    // target
    // ------------------------------

    assign is_jalr = instr.br_op == exu_op_pkg::br_jalr;
    assign base = is_jalr ? instr.rs1 : instr.pc;
    assign sum = base + instr.imm;
    // jalr drops bit 0 of the computed address
    assign br_res.target = is_jalr ? {sum[XLEN-1:1], 1'b0} : sum;

endmodule

// ==== hw/exu_stage.sv ====
`timescale 1ns/1ps

module exu_stage #(
    parameter int XLEN = 32
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  exu_bus_pkg::exu_in_t  in_instr,
    input  exu_bus_pkg::alu_res_t alu_res,
    input  exu_bus_pkg::br_res_t  br_res,
    output logic                  out_valid,
    input  logic                  out_ready,
    output exu_bus_pkg::exu_out_t out_rec,
    output logic                  redirect_valid,
    output logic [XLEN-1:0]       redirect_pc,
    input  logic                  load_finish
);

    logic                              accept;
    logic                              is_load;
    logic                              lock_valid;
    logic [exu_bus_pkg::REG_IDX_W-1:0] lock_idx;
    logic                              lock_hit;

    // ------------------------------
    // handshake and load-use lock
    // ------------------------------

    // register zero never waits on a load
    assign lock_hit = lock_valid && (lock_idx != '0)
                      && (in_instr.rs1_idx == lock_idx || in_instr.rs2_idx == lock_idx);
    assign in_ready = !out_valid && !lock_hit;
    assign accept = in_valid && in_ready;

    assign is_load = in_instr.mem_op == exu_op_pkg::mem_load;

    always_ff @(posedge clock) begin
        if (reset) begin
            lock_valid <= 1'b0;
        end else if (accept && is_load) begin
            // a newer load replaces the one still outstanding
            lock_valid <= 1'b1;
            lock_idx <= in_instr.rd_idx;
        end else if (load_finish) begin
            lock_valid <= 1'b0;
        end
    end

    // ------------------------------
    // output record
    // ------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            out_rec.rd_idx <= in_instr.rd_idx;
            out_rec.rd_en <= in_instr.rd_en;
            out_rec.result <= alu_res.result;
            out_rec.mem_op <= in_instr.mem_op;
            out_rec.mem_size <= in_instr.mem_size;
            out_rec.mem_unsigned <= in_instr.mem_unsigned;
            out_rec.store_data <= in_instr.rs2;
        end
    end

    // ------------------------------
    // redirect pulse
    // ------------------------------

    // jumps always come in with taken set by the branch unit
    always_ff @(posedge clock) begin
        if (reset) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= accept && br_res.taken;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            redirect_pc <= br_res.target;
        end
    end

    // ------------------------------
    // assertions
    // ------------------------------

    // record held under back-pressure
    a_out_stable: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_rec));

    a_redirect_pulse: assert property (@(posedge clock) disable iff (reset)
        redirect_valid |=> !redirect_valid);

endmodule

// ==== hw/exu_top.sv ====
`timescale 1ns/1ps

module exu_top #(
    parameter int XLEN = 32
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  exu_bus_pkg::exu_in_t  in_instr,
    output logic                  out_valid,
    input  logic                  out_ready,
    output exu_bus_pkg::exu_out_t out_rec,
    output logic                  redirect_valid,
    output logic [XLEN-1:0]       redirect_pc,
    input  logic                  load_finish
);

    exu_bus_pkg::alu_res_t alu_res;
    exu_bus_pkg::br_res_t  br_res;

    // both units see the same instruction in the same cycle
    exu_alu #(
        .XLEN(XLEN)
    ) u_alu (
        .instr   (in_instr),
        .alu_res (alu_res)
    );

    exu_branch #(
        .XLEN(XLEN)
    ) u_branch (
        .instr  (in_instr),
        .br_res (br_res)
    );

    exu_stage #(
        .XLEN(XLEN)
    ) u_stage (
        .clock          (clock),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_instr       (in_instr),
        .alu_res        (alu_res),
        .br_res         (br_res),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_rec        (out_rec),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .load_finish    (load_finish)
    );

endmodule

// ==== verification/exu_tb_clock.sv ====
`timescale 1ns/1ps

module exu_tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // released on a rising edge, like the synchronous reset it feeds
    initial begin
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

// ==== verification/exu_tb.sv ====
`timescale 1ns/1ps

module exu_tb;

    localparam int XLEN = 32;
    localparam int CLOCK_PERIOD_NS = 8;
    localparam int RESET_CYCLES = 8;
    localparam int ALU_ROUNDS = 4;
    localparam int BR_ROUNDS = 4;
    localparam int JUMP_ROUNDS = 4;
    localparam int MEM_ROUNDS = 8;
    localparam int BP_ROUNDS = 6;
    localparam int LOCK_WAIT = 5;
    // lock test issues eight instructions
    localparam int ISSUE_COUNT = 11 * ALU_ROUNDS + 6 * BR_ROUNDS + 2 * JUMP_ROUNDS
                                 + MEM_ROUNDS + BP_ROUNDS + 8;
    localparam int TIMEOUT_NS = (RESET_CYCLES + ISSUE_COUNT * 20 + 100) * CLOCK_PERIOD_NS;

    logic                  clock;
    logic                  reset;
    logic                  in_valid;
    logic                  in_ready;
    exu_bus_pkg::exu_in_t  in_instr;
    logic                  out_valid;
    logic                  out_ready;
    exu_bus_pkg::exu_out_t out_rec;
    logic                  redirect_valid;
    logic [XLEN-1:0]       redirect_pc;
    logic                  load_finish;
    int                    error_count;

    exu_tb_clock #(
        .PERIOD_NS    (CLOCK_PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .clock (clock),
        .reset (reset)
    );

    exu_top #(
        .XLEN(XLEN)
    ) uut (
        .clock          (clock),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_instr       (in_instr),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_rec        (out_rec),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .load_finish    (load_finish)
    );

    // ------------------------------
    // reference model
    // ------------------------------

    function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
        // differing signs decide on their own
        if (a[31] != b[31]) begin
            return a[31];
        end
        return a < b;
    endfunction

    function automatic logic [31:0] model_alu(input exu_op_pkg::alu_op_e op,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (op)
            exu_op_pkg::alu_add:    return a + b;
            exu_op_pkg::alu_sub:    return a - b;
            exu_op_pkg::alu_sll:    return a << sh;
            exu_op_pkg::alu_slt:    return {31'b0, signed_less(a, b)};
            exu_op_pkg::alu_sltu:   return {31'b0, a < b};
            exu_op_pkg::alu_xor:    return a ^ b;
            exu_op_pkg::alu_srl:    return a >> sh;
            exu_op_pkg::alu_sra:    return (a >> sh) | fill;
            exu_op_pkg::alu_or:     return a | b;
            exu_op_pkg::alu_and:    return a & b;
            exu_op_pkg::alu_pass_b: return b;
            default:                return 32'h0;
        endcase
    endfunction

    function automatic logic model_taken(input exu_op_pkg::br_op_e op,
                                         input logic [31:0] a, input logic [31:0] b);
        case (op)
            exu_op_pkg::br_beq:  return a == b;
            exu_op_pkg::br_bne:  return a != b;
            exu_op_pkg::br_blt:  return signed_less(a, b);
            exu_op_pkg::br_bge:  return !signed_less(a, b);
            exu_op_pkg::br_bltu: return a < b;
            exu_op_pkg::br_bgeu: return a >= b;
            exu_op_pkg::br_jal:  return 1'b1;
            exu_op_pkg::br_jalr: return 1'b1;
            default:             return 1'b0;
        endcase
    endfunction

    // plain register-register add with random fields
    function automatic exu_bus_pkg::exu_in_t random_instr();
        exu_bus_pkg::exu_in_t instr;
        instr = '0;
        instr.alu_op = exu_op_pkg::alu_add;
        instr.rd_idx = 5'($urandom);
        instr.rs1_idx = 5'($urandom);
        instr.rs2_idx = 5'($urandom);
        instr.rd_en = 1'b1;
        instr.pc = $urandom & 32'hffff_fffc;
        instr.imm = $urandom;
        instr.rs1 = $urandom;
        instr.rs2 = $urandom;
        return instr;
    endfunction

    // ------------------------------
    // checking and driving
    // ------------------------------

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // transfer one instruction, hold out_ready low for hold cycles, collect the record
    task automatic issue(input exu_bus_pkg::exu_in_t instr, input int hold,
                         output exu_bus_pkg::exu_out_t rec, output logic redir,
                         output logic [31:0] redir_pc, output int waits);
        waits = 0;
        @(posedge clock);
        in_valid <= 1'b1;
        in_instr <= instr;
        out_ready <= (hold == 0);
        @(negedge clock);
        check(32'(redirect_valid), 32'd0, "redirect_valid before accept");
        while (!in_ready) begin
            waits++;
            @(negedge clock);
        end
        @(posedge clock);
        in_valid <= 1'b0;
        @(negedge clock);
        check(32'(out_valid), 32'd1, "out_valid after accept");
        rec = out_rec;
        redir = redirect_valid;
        redir_pc = redirect_pc;
        for (int i = 0; i < hold; i++) begin
            check(32'(out_valid), 32'd1, "out_valid under back-pressure");
            check(32'(out_rec == rec), 32'd1, "out_rec held under back-pressure");
            check(32'(in_ready), 32'd0, "in_ready while record held");
            @(posedge clock);
            if (i == hold - 1) begin
                out_ready <= 1'b1;
            end
            @(negedge clock);
            check(32'(redirect_valid), 32'd0, "redirect_valid second cycle");
        end
        check(32'(out_valid), 32'd1, "out_valid before consume");
        check(32'(out_rec == rec), 32'd1, "out_rec before consume");
        @(posedge clock);
        @(negedge clock);
        check(32'(out_valid), 32'd0, "record consumed");
        check(32'(redirect_valid), 32'd0, "redirect_valid after pulse");
    endtask

    task automatic pulse_load_finish();
        @(posedge clock);
        load_finish <= 1'b1;
        @(posedge clock);
        load_finish <= 1'b0;
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------

    task automatic test_alu();
        exu_bus_pkg::exu_in_t  instr;
        exu_bus_pkg::exu_out_t rec;
        logic                  redir;
        logic [31:0]           rpc;
        int                    waits;
        logic [31:0]           op_a;
        logic [31:0]           op_b;
        for (int op = 0; op <= 10; op++) begin
            for (int n = 0; n < ALU_ROUNDS; n++) begin
                instr = random_instr();
                instr.alu_op = exu_op_pkg::alu_op_e'(4'(op));
                instr.src_a = exu_op_pkg::src_a_e'(1'(n));
                instr.src_b = exu_op_pkg::src_b_e'(1'(n >> 1));
                op_a = instr.src_a == exu_op_pkg::src_a_pc ? instr.pc : instr.rs1;
                op_b = instr.src_b == exu_op_pkg::src_b_imm ? instr.imm : instr.rs2;
                issue(instr, 0, rec, redir, rpc, waits);
                check(rec.result, model_alu(instr.alu_op, op_a, op_b), "alu result");
                check(32'(rec.rd_idx), 32'(instr.rd_idx), "alu rd_idx");
                check(32'(redir), 32'd0, "no redirect for alu op");
            end
        end
    endtask

    task automatic test_branch();
        exu_bus_pkg::exu_in_t  instr;
        exu_bus_pkg::exu_out_t rec;
        logic                  redir;
        logic [31:0]           rpc;
        int                    waits;
        logic                  taken;
        for (int k = 0; k < 6; k++) begin
            for (int n = 0; n < BR_ROUNDS; n++) begin
                instr = random_instr();
                instr.br_op = exu_op_pkg::br_op_e'(4'(3 + k));
                instr.rd_en = 1'b0;
                if (n % 2 == 0) begin
                    instr.rs2 = instr.rs1;
                end
                taken = model_taken(instr.br_op, instr.rs1, instr.rs2);
                issue(instr, 0, rec, redir, rpc, waits);
                check(32'(redir), 32'(taken), "conditional redirect");
                if (taken) begin
                    check(rpc, instr.pc + instr.imm, "branch target");
                end
            end
        end
        for (int n = 0; n < 2 * JUMP_ROUNDS; n++) begin
            instr = random_instr();
            instr.br_op = (n % 2 == 0) ? exu_op_pkg::br_jal : exu_op_pkg::br_jalr;
            // link address from pc plus a constant 4 on the rs2 operand
            instr.src_a = exu_op_pkg::src_a_pc;
            instr.src_b = exu_op_pkg::src_b_rs2;
            instr.rs2 = 32'd4;
            issue(instr, 0, rec, redir, rpc, waits);
            check(32'(redir), 32'd1, "jump redirect");
            check(rec.result, instr.pc + 32'd4, "jump link result");
            if (instr.br_op == exu_op_pkg::br_jal) begin
                check(rpc, instr.pc + instr.imm, "jal target");
            end else begin
                check(rpc, (instr.rs1 + instr.imm) & 32'hffff_fffe, "jalr target");
            end
        end
    endtask

    task automatic test_mem();
        exu_bus_pkg::exu_in_t  instr;
        exu_bus_pkg::exu_out_t rec;
        logic                  redir;
        logic [31:0]           rpc;
        int                    waits;
        for (int n = 0; n < MEM_ROUNDS; n++) begin
            instr = random_instr();
            instr.src_b = exu_op_pkg::src_b_imm;
            instr.mem_op = (n % 2 == 0) ? exu_op_pkg::mem_load : exu_op_pkg::mem_store;
            instr.mem_size = exu_op_pkg::mem_size_e'(2'($urandom_range(2, 0)));
            instr.mem_unsigned = 1'($urandom);
            instr.rd_en = instr.mem_op == exu_op_pkg::mem_load;
            issue(instr, 0, rec, redir, rpc, waits);
            check(rec.result, instr.rs1 + instr.imm, "memory address");
            check(rec.store_data, instr.rs2, "store data");
            check(32'(rec.mem_op), 32'(instr.mem_op), "mem_op");
            check(32'(rec.mem_size), 32'(instr.mem_size), "mem_size");
            check(32'(rec.mem_unsigned), 32'(instr.mem_unsigned), "mem_unsigned");
            check(32'(rec.rd_idx), 32'(instr.rd_idx), "memory rd_idx");
            check(32'(rec.rd_en), 32'(instr.rd_en), "memory rd_en");
            if (instr.mem_op == exu_op_pkg::mem_load) begin
                pulse_load_finish();
            end
        end
    endtask

    task automatic test_backpressure();
        exu_bus_pkg::exu_in_t  instr;
        exu_bus_pkg::exu_out_t rec;
        logic                  redir;
        logic [31:0]           rpc;
        int                    waits;
        for (int n = 0; n < BP_ROUNDS; n++) begin
            instr = random_instr();
            issue(instr, int'($urandom_range(10, 1)), rec, redir, rpc, waits);
            check(rec.result, instr.rs1 + instr.rs2, "result after back-pressure");
        end
    endtask

    task automatic test_lock();
        exu_bus_pkg::exu_in_t  load;
        exu_bus_pkg::exu_in_t  user;
        exu_bus_pkg::exu_out_t rec;
        logic                  redir;
        logic [31:0]           rpc;
        int                    waits;
        logic [4:0]            r;
        for (int round = 0; round < 2; round++) begin
            r = 5'($urandom_range(31, 1));
            load = random_instr();
            load.mem_op = exu_op_pkg::mem_load;
            load.src_b = exu_op_pkg::src_b_imm;
            load.rd_idx = r;
            issue(load, 0, rec, redir, rpc, waits);
            user = random_instr();
            // first round reads r through rs1, second through rs2
            user.rs1_idx = (round == 0) ? r : r ^ 5'd1;
            user.rs2_idx = (round == 0) ? r ^ 5'd2 : r;
            @(posedge clock);
            in_valid <= 1'b1;
            in_instr <= user;
            out_ready <= 1'b1;
            repeat (LOCK_WAIT) begin
                @(negedge clock);
                check(32'(in_ready), 32'd0, "in_ready on load-use");
            end
            @(posedge clock);
            load_finish <= 1'b1;
            @(negedge clock);
            check(32'(in_ready), 32'd0, "in_ready during load_finish");
            @(posedge clock);
            load_finish <= 1'b0;
            in_valid <= 1'b0;
            @(negedge clock);
            check(32'(in_ready), 32'd1, "in_ready after load_finish");
            issue(user, 0, rec, redir, rpc, waits);
            check(rec.result, user.rs1 + user.rs2, "result after lock");
        end
        // independent reader goes straight through
        r = 5'($urandom_range(31, 1));
        load.rd_idx = r;
        issue(load, 0, rec, redir, rpc, waits);
        user = random_instr();
        user.rs1_idx = r ^ 5'd1;
        user.rs2_idx = r ^ 5'd2;
        issue(user, 0, rec, redir, rpc, waits);
        check(32'(waits), 32'd0, "independent reader waited");
        pulse_load_finish();
        // loads to x0 lock nothing
        load.rd_idx = 5'd0;
        issue(load, 0, rec, redir, rpc, waits);
        user.rs1_idx = 5'd0;
        user.rs2_idx = 5'd0;
        issue(user, 0, rec, redir, rpc, waits);
        check(32'(waits), 32'd0, "x0 reader waited");
        pulse_load_finish();
    endtask

    // ------------------------------
    // run control
    // ------------------------------

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        error_count = 0;
        void'($urandom(32'h67db_8e18));
        in_valid <= 1'b0;
        in_instr <= '0;
        out_ready <= 1'b0;
        load_finish <= 1'b0;
        @(negedge clock);
        while (reset) begin
            @(negedge clock);
        end
        test_alu();
        test_branch();
        test_mem();
        test_backpressure();
        test_lock();
        if (error_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

// ==== flist.f ====
hw/exu_op_pkg.sv
hw/exu_bus_pkg.sv
hw/exu_alu.sv
hw/exu_branch.sv
hw/exu_stage.sv
hw/exu_top.sv
verification/exu_tb_clock.sv
verification/exu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert \
    --top-module exu_tb \
    -f flist.f \
    -o exu_sim

./obj_dir/exu_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

# no pass line means the run stopped early
grep -q "RESULT: PASS" sim.log
